// File: include/mimo_config.svh
// sizing macros for the multi-lane branch writer, included by the package and RTL modules
`ifndef MIMO_CONFIG_SVH
`define MIMO_CONFIG_SVH

// number of input lanes, also the number of output branches
`define MIMO_NUM_LANES 8

// payload word width
`define MIMO_DATA_WIDTH 16

// log2 of the lane count
`define MIMO_BRANCH_WIDTH 3

// entries per lane FIFO, keep this a power of two
`define MIMO_FIFO_DEPTH 16

`endif

// File: hw/mimo_pkg.sv
// shared types for the branch writer, imported by every RTL module and the testbench
`default_nettype none

`include "mimo_config.svh"

package mimo_pkg;

    typedef logic [`MIMO_DATA_WIDTH-1:0] data_t;

    typedef logic [`MIMO_BRANCH_WIDTH-1:0] branch_t;

    typedef logic [`MIMO_BRANCH_WIDTH-1:0] lane_idx_t;

    // one bit per lane or per branch
    typedef logic [`MIMO_NUM_LANES-1:0] lane_mask_t;

    // what a lane FIFO stores, branch in the upper bits
    typedef struct packed {
        branch_t branch;
        data_t   data;
    } lane_entry_t;

endpackage : mimo_pkg

`default_nettype wire

// File: hw/lane_fifo.sv
// show-ahead FIFO with valid/ready on both sides that the top level instantiates once per lane
`timescale 1ns/10ps
`default_nettype none

`include "mimo_config.svh"

module lane_fifo #(
    parameter integer DEPTH = `MIMO_FIFO_DEPTH
) (
    input  wire logic                 i_clock,
    input  wire logic                 i_reset,
    input  wire mimo_pkg::lane_entry_t i_in_entry,
    input  wire logic                 i_in_valid,
    output      logic                 o_in_ready,
    output      mimo_pkg::lane_entry_t o_out_entry,
    output      logic                 o_out_valid,
    input  wire logic                 i_out_ready
);

    import mimo_pkg::*;

    localparam integer PTR_WIDTH   = $clog2(DEPTH);
    localparam integer COUNT_WIDTH = $clog2(DEPTH + 1);

    // distributed storage array
    lane_entry_t mem [DEPTH];

    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   push;
    logic                   pop;

    assign o_in_ready  = (count < COUNT_WIDTH'(DEPTH));
    assign o_out_valid = (count != '0);

    assign push = i_in_valid & o_in_ready;
    assign pop  = i_out_ready & o_out_valid;

    // head is read straight from the array
    assign o_out_entry = mem[rd_ptr];

    always_ff @(posedge i_clock) begin
        if (push) begin
            mem[wr_ptr] <= i_in_entry;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule : lane_fifo

`default_nettype wire

// File: hw/rr_arbiter.sv
// rotating-priority pick of one non-empty lane per cycle for the branch router
`timescale 1ns/10ps
`default_nettype none

`include "mimo_config.svh"

module rr_arbiter (
    input  wire logic                  i_clock,
    input  wire logic                  i_reset,
    input  wire mimo_pkg::lane_mask_t  i_lane_valid,
    input  wire mimo_pkg::lane_entry_t i_lane_entry [`MIMO_NUM_LANES],
    output      mimo_pkg::lane_mask_t  o_lane_pop,
    output      mimo_pkg::lane_entry_t o_grant_entry,
    output      logic                  o_grant_valid
);

    import mimo_pkg::*;

    localparam integer NUM_LANES = `MIMO_NUM_LANES;

    // lane that gets first look this cycle
    lane_idx_t priority_ptr;
    lane_idx_t winner;
    logic      found;

    // walk the lanes from the pointer and wrap past the last one
    always_comb begin
        lane_idx_t cand;
        found  = 1'b0;
        winner = priority_ptr;
        for (int i = 0; i < NUM_LANES; i++) begin
            cand = lane_idx_t'((int'(priority_ptr) + i) % NUM_LANES);
            if (!found && i_lane_valid[cand]) begin
                found  = 1'b1;
                winner = cand;
            end
        end
    end

    assign o_grant_valid = found;
    assign o_lane_pop    = found ? (lane_mask_t'(1) << winner) : '0;
    assign o_grant_entry = found ? i_lane_entry[winner] : '0;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            priority_ptr <= '0;
        end else if (found) begin
            // winner drops to lowest priority next cycle, the index width wraps lane 7 to 0
            priority_ptr <= winner + 1'b1;
        end
    end

endmodule : rr_arbiter

`default_nettype wire

// File: hw/branch_router.sv
// output register stage, broadcasts the granted word and flags only its destination branch
`timescale 1ns/10ps
`default_nettype none

module branch_router (
    input  wire logic                  i_clock,
    input  wire logic                  i_reset,
    input  wire mimo_pkg::lane_entry_t i_entry,
    input  wire logic                  i_entry_valid,
    output      mimo_pkg::data_t       o_data,
    output      mimo_pkg::lane_mask_t  o_valid
);

    import mimo_pkg::*;

    lane_mask_t branch_onehot;

    // one-hot decode of the branch, empty when nothing was granted
    assign branch_onehot = i_entry_valid ? (lane_mask_t'(1) << i_entry.branch) : '0;

    // data goes to every branch whether valid or not
    always_ff @(posedge i_clock) begin
        o_data <= i_entry.data;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_valid <= '0;
        end else begin
            o_valid <= branch_onehot;
        end
    end

endmodule : branch_router

`default_nettype wire

// File: hw/mimo_fifo.sv
// top level of the branch writer, eight buffered lanes merged round-robin onto one output
`timescale 1ns/10ps
`default_nettype none

`include "mimo_config.svh"

module mimo_fifo (
    input  wire logic                 i_clock,
    input  wire logic                 i_reset,
    input  wire mimo_pkg::data_t      i_data   [`MIMO_NUM_LANES],
    input  wire mimo_pkg::branch_t    i_branch [`MIMO_NUM_LANES],
    input  wire logic                 i_valid,
    output      logic                 o_ready,
    output      mimo_pkg::data_t      o_data,
    output      mimo_pkg::lane_mask_t o_valid
);

    import mimo_pkg::*;

    localparam integer NUM_LANES = `MIMO_NUM_LANES;

    lane_entry_t lane_in_entry  [NUM_LANES];
    lane_entry_t lane_out_entry [NUM_LANES];
    lane_mask_t  lane_in_ready;
    lane_mask_t  lane_out_valid;
    lane_mask_t  lane_pop;
    lane_entry_t grant_entry;
    logic        grant_valid;
    logic        beat_accept;

    // all lanes move together, so one full lane stalls the whole beat
    assign o_ready = &lane_in_ready;

    // no lane may write unless every lane can
    assign beat_accept = i_valid & o_ready;

    genvar g;
    generate
        for (g = 0; g < NUM_LANES; g++) begin : g_lane
            assign lane_in_entry[g].branch = i_branch[g];
            assign lane_in_entry[g].data   = i_data[g];

            lane_fifo #(
                .DEPTH(`MIMO_FIFO_DEPTH)
            ) u_lane_fifo (
                .i_clock    (i_clock),
                .i_reset    (i_reset),
                .i_in_entry (lane_in_entry[g]),
                .i_in_valid (beat_accept),
                .o_in_ready (lane_in_ready[g]),
                .o_out_entry(lane_out_entry[g]),
                .o_out_valid(lane_out_valid[g]),
                .i_out_ready(lane_pop[g])
            );
        end
    endgenerate

    rr_arbiter u_rr_arbiter (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_lane_valid (lane_out_valid),
        .i_lane_entry (lane_out_entry),
        .o_lane_pop   (lane_pop),
        .o_grant_entry(grant_entry),
        .o_grant_valid(grant_valid)
    );

    // one register stage between the grant and the memory side
    branch_router u_branch_router (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_entry      (grant_entry),
        .i_entry_valid(grant_valid),
        .o_data       (o_data),
        .o_valid      (o_valid)
    );

endmodule : mimo_fifo

`default_nettype wire

// File: test/tb_mimo_fifo.sv
// self-checking testbench that drives the branch writer top level as the simulation top
`timescale 1ns/10ps
`default_nettype none

`include "mimo_config.svh"

module tb_mimo_fifo;

    import mimo_pkg::*;

    localparam integer NUM_LANES  = `MIMO_NUM_LANES;
    localparam integer DATA_W     = `MIMO_DATA_WIDTH;
    localparam integer BRANCH_W   = `MIMO_BRANCH_WIDTH;
    localparam integer SEQ_W      = DATA_W - BRANCH_W;
    localparam integer MAX_CYCLES = 3000;

    logic       i_clock;
    logic       i_reset;
    data_t      i_data   [NUM_LANES];
    branch_t    i_branch [NUM_LANES];
    logic       i_valid;
    logic       o_ready;
    data_t      o_data;
    lane_mask_t o_valid;

    // expected entries per lane with the oldest first
    lane_entry_t exp_q [NUM_LANES][$];
    int          lane_seq [NUM_LANES];
    int          errors;
    int          beats_accepted;
    int          pulse_count;
    int          cycle_count;
    logic        rotation_check;
    logic        ready_fell;

    mimo_fifo u_mimo_fifo (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_data  (i_data),
        .i_branch(i_branch),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .o_data  (o_data),
        .o_valid (o_valid)
    );

    always #5 i_clock = ~i_clock;

    // valid mask with only the destination branch set
    function automatic lane_mask_t expected_mask(input branch_t branch);
        lane_mask_t mask;
        mask         = '0;
        mask[branch] = 1'b1;
        return mask;
    endfunction

    // state in the first cycle after reset release
    assert property (@(posedge i_clock) $fell(i_reset) |-> (o_valid == '0))
        else begin
            errors++;
            $display("MISMATCH at %0t: o_valid expected %b got %b",
                     $time, lane_mask_t'(0), $sampled(o_valid));
        end

    assert property (@(posedge i_clock) $fell(i_reset) |-> o_ready)
        else begin
            errors++;
            $display("MISMATCH at %0t: o_ready expected 1 got %b", $time, $sampled(o_ready));
        end

    assert property (@(posedge i_clock) $fell(i_reset) |-> (o_data == '0))
        else begin
            errors++;
            $display("MISMATCH at %0t: o_data expected %h got %h",
                     $time, data_t'(0), $sampled(o_data));
        end

    assert property (@(posedge i_clock) disable iff (i_reset) $onehot0(o_valid))
        else begin
            errors++;
            $display("o_valid has more than one branch set at %0t: %b", $time, $sampled(o_valid));
        end

    // outputs are checked before the new beat is queued
    always @(posedge i_clock) begin
        lane_entry_t head;
        int          lane;
        if (!i_reset && !o_ready) begin
            ready_fell = 1'b1;
        end
        if (o_valid != '0) begin
            lane = int'(o_data[DATA_W-1 -: BRANCH_W]);
            if (rotation_check && pulse_count < 3 * NUM_LANES) begin
                assert (lane == pulse_count % NUM_LANES)
                    else begin
                        errors++;
                        $display("MISMATCH at %0t: o_data lane expected %0d got %0d",
                                 $time, pulse_count % NUM_LANES, lane);
                    end
            end
            pulse_count++;
            assert (exp_q[lane].size() != 0)
                else begin
                    errors++;
                    $display("output at %0t names lane %0d, which has nothing pending",
                             $time, lane);
                end
            if (exp_q[lane].size() != 0) begin
                head = exp_q[lane].pop_front();
                assert (o_data == head.data)
                    else begin
                        errors++;
                        $display("MISMATCH at %0t: o_data expected %h got %h",
                                 $time, head.data, o_data);
                    end
                assert ($onehot(o_valid) && o_valid[head.branch])
                    else begin
                        errors++;
                        $display("MISMATCH at %0t: o_valid expected %b got %b",
                                 $time, expected_mask(head.branch), o_valid);
                    end
            end
        end
        if (i_valid && o_ready) begin
            beats_accepted++;
            for (int l = 0; l < NUM_LANES; l++) begin
                exp_q[l].push_back('{branch: i_branch[l], data: i_data[l]});
            end
        end
    end

    always @(posedge i_clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles, outputs stalled", cycle_count);
            $display("beats %0d, outputs %0d, errors %0d", beats_accepted, pulse_count, errors);
            $display("Something failed");
            $finish;
        end
    end

    // lane number in the top bits and the per-lane sequence below
    task automatic drive_beat();
        for (int l = 0; l < NUM_LANES; l++) begin
            i_data[l]   <= {lane_idx_t'(l), SEQ_W'(lane_seq[l])};
            i_branch[l] <= branch_t'($urandom);
        end
        i_valid <= 1'b1;
    endtask

    // a beat stays on the inputs until it is taken
    task automatic send_beats(input int num_beats, input int valid_pct);
        int   sent;
        logic held;
        sent = 0;
        held = 1'b0;
        while (sent < num_beats) begin
            @(posedge i_clock);
            if (i_valid && o_ready) begin
                sent++;
                held = 1'b0;
                for (int l = 0; l < NUM_LANES; l++) begin
                    lane_seq[l]++;
                end
            end
            if (sent >= num_beats) begin
                i_valid <= 1'b0;
            end else if (!held) begin
                if (($urandom % 100) < valid_pct) begin
                    drive_beat();
                    held = 1'b1;
                end else begin
                    i_valid <= 1'b0;
                end
            end
        end
    endtask

    task automatic wait_drain();
        @(negedge i_clock);
        while (pulse_count != NUM_LANES * beats_accepted) begin
            @(negedge i_clock);
        end
        repeat (4) @(negedge i_clock);
        assert (pulse_count == NUM_LANES * beats_accepted)
            else begin
                errors++;
                $display("MISMATCH at %0t: output pulses expected %0d got %0d",
                         $time, NUM_LANES * beats_accepted, pulse_count);
            end
        for (int l = 0; l < NUM_LANES; l++) begin
            assert (exp_q[l].size() == 0)
                else begin
                    errors++;
                    $display("lane %0d still has %0d entries that never came out",
                             l, exp_q[l].size());
                end
        end
    endtask

    initial begin
        void'($urandom(21180));
        i_clock        = 1'b0;
        i_reset        = 1'b1;
        i_valid        = 1'b0;
        errors         = 0;
        beats_accepted = 0;
        pulse_count    = 0;
        cycle_count    = 0;
        rotation_check = 1'b0;
        ready_fell     = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            i_data[l]   = '0;
            i_branch[l] = '0;
            lane_seq[l] = 0;
        end

        repeat (16) @(posedge i_clock);
        i_reset <= 1'b0;

        // three back-to-back beats then idle with the pointer at lane 0
        rotation_check = 1'b1;
        send_beats(3, 100);
        wait_drain();
        rotation_check = 1'b0;

        send_beats(40, 60);
        wait_drain();

        // eight entries go in per beat but only one comes out per cycle
        ready_fell = 1'b0;
        send_beats(30, 100);
        wait_drain();
        assert (ready_fell)
            else begin
                errors++;
                $display("o_ready never dropped under continuous input beats");
            end

        $display("beats %0d, outputs %0d, errors %0d", beats_accepted, pulse_count, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : tb_mimo_fifo

`default_nettype wire

// File: project.f
+incdir+include
hw/mimo_pkg.sv
hw/lane_fifo.sv
hw/rr_arbiter.sv
hw/branch_router.sv
hw/mimo_fifo.sv
test/tb_mimo_fifo.sv
